// ==== design/dataRam.sv ====
// Memory stage scratch RAM that serves loads and stores and produces the stage result
module dataRam (
  input  logic                clk,
  input  logic                rst,
  input  hazardPkg::stageDesc memStage,
  output hazardPkg::dataWord  memResult
);
  import hazardPkg::*;

  dataWord                ram [ramWords];
  logic [ramAddrBits-1:0] addr;
  logic                   storeEn;

  // Only the low address bits matter, so the space wraps every ramWords words
  assign addr    = memStage.result[ramAddrBits-1:0];
  assign storeEn = memStage.valid && (memStage.kind == opStore);

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < ramWords; i++) begin
        ram[i] <= '0;
      end
    end else if (storeEn) begin
      // Forwarded rs2 value from execute
      ram[addr] <= memStage.val2;
    end
  end

  ////////////////////
  // Stage result
  ////////////////////

  // Loads read combinationally so the word is ready in this same cycle
  // Every other op passes its execute result on to writeback
  assign memResult = (memStage.kind == opLoad) ? ram[addr] : memStage.result;

endmodule

// ==== design/execUnit.sv ====
// Execute stage datapath with operand forwarding muxes, adder and branch compare
module execUnit (
  input  hazardPkg::stageDesc exeStage,
  input  hazardPkg::fwdSel    fwdA,
  input  hazardPkg::fwdSel    fwdB,
  input  hazardPkg::dataWord  memFwd,
  input  hazardPkg::dataWord  wbFwd,
  output hazardPkg::dataWord  exeA,
  output hazardPkg::dataWord  exeB,
  output hazardPkg::dataWord  exeResult,
  output logic                branchTaken
);
  import hazardPkg::*;

  dataWord addrSum;

  // Three-way operand source select shared by both operands
  function automatic dataWord pickOperand(fwdSel sel, dataWord stageVal,
                                          dataWord memVal, dataWord wbVal);
    dataWord picked;
    case (sel)
      fwdMem:  picked = memVal;
      fwdWb:   picked = wbVal;
      default: picked = stageVal;
    endcase
    return picked;
  endfunction

  ////////////////////
  // Operands
  ////////////////////

  assign exeA = pickOperand(fwdA, exeStage.val1, memFwd, wbFwd);
  assign exeB = pickOperand(fwdB, exeStage.val2, memFwd, wbFwd);

  ////////////////////
  // Result and resolve
  ////////////////////

  // Loads and stores address the RAM with rs1 plus the immediate
  assign addrSum = exeA + exeStage.imm;

  always_comb begin
    if (exeStage.kind == opAdd) begin
      exeResult = addrSum + exeB;
    end else begin
      exeResult = addrSum;
    end
  end

  // Branch is taken on equal operands, and only a live op may redirect
  assign branchTaken = exeStage.valid && (exeStage.kind == opBranch) && (exeA == exeB);

endmodule

// ==== design/hazard.sv ====
// Pipeline control that picks forwarding sources and raises stalls and flushes per stage
module hazard (
  input  hazardPkg::stageDesc exeStage,
  input  hazardPkg::stageDesc memStage,
  input  hazardPkg::stageDesc wbStage,
  input  hazardPkg::stageDesc decStage,
  input  logic                branchTaken,
  input  logic                inValid,
  output hazardPkg::fwdSel    fwdA,
  output hazardPkg::fwdSel    fwdB,
  output logic                stallF,
  output logic                stallD,
  output logic                flushD,
  output logic                flushE,
  output logic                flushM,
  output logic                flushW
);
  import hazardPkg::*;

  logic loadE;
  logic retM;
  logic trapM;
  logic fetchBubble;
  logic loadStall;

  // Memory stage wins over writeback since it holds the younger value
  function automatic fwdSel selectSource(regIdx src, stageDesc memS, stageDesc wbS);
    fwdSel sel;
    sel = fwdReg;
    // Register zero always reads as zero, so it is never forwarded
    if (src != '0) begin
      if (memS.valid && memS.regWrite && memS.rd == src) sel = fwdMem;
      else if (wbS.valid && wbS.regWrite && wbS.rd == src) sel = fwdWb;
    end
    return sel;
  endfunction

  ////////////////////
  // Forwarding
  ////////////////////

  assign fwdA = selectSource(exeStage.rs1, memStage, wbStage);
  assign fwdB = selectSource(exeStage.rs2, memStage, wbStage);

  ////////////////////
  // Stalls and flushes
  ////////////////////

  assign loadE       = exeStage.valid & exeStage.memRead;
  assign retM        = memStage.valid & (memStage.kind == opRet);
  assign trapM       = memStage.valid & (memStage.kind == opTrap);
  assign fetchBubble = ~inValid;

  // Hold decode one cycle when it reads the register a load in execute will write
  // A load that ret or trap is about to discard has nothing worth waiting for
  assign loadStall = loadE & ~(retM | trapM) &
                     ((decStage.rs1 == exeStage.rd) | (decStage.rs2 == exeStage.rd));

  assign stallD = loadStall;
  assign stallF = stallD | fetchBubble;

  // Taken branch kills the two younger ops, ret and trap kill three
  assign flushD = branchTaken | fetchBubble | retM | trapM;
  assign flushE = loadStall | branchTaken | retM | trapM;
  assign flushM = retM | trapM;
  // Trap also discards itself on its way into writeback
  assign flushW = trapM;

  always_comb begin
    // Branch and load share execute, so a decode stall only meets an idle-fetch flush
    assert (!(stallD && flushD && inValid))
      else $error("hazard: decode stall overlaps a control flush");
    assert (!flushW || flushM)
      else $error("hazard: writeback flushed while memory stage kept");
  end

endmodule

// ==== design/hazardPkg.sv ====
// Shared types and sizes for the five-stage pipeline core; every RTL file imports it
package hazardPkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Architectural register count, with register zero hardwired to zero
  localparam int numRegs = 32;
  // Scratch RAM depth in words
  localparam int ramWords = 16;
  // Low address bits that pick a RAM word
  localparam int ramAddrBits = $clog2(ramWords);

  ////////////////////
  // Base types
  ////////////////////

  typedef logic [4:0] regIdx;
  typedef logic [31:0] dataWord;

  // Operation codes carried by each micro-op
  typedef enum logic [2:0] {
    opAdd,
    opLoad,
    opStore,
    opBranch,
    opRet,
    opTrap
  } opKind;

  // Operand source in execute, encoded as 00 register, 01 writeback, 10 memory
  typedef enum logic [1:0] {
    fwdReg = 2'b00,
    fwdWb  = 2'b01,
    fwdMem = 2'b10
  } fwdSel;

  // One decoded micro-op as presented on the fetch port
  typedef struct packed {
    opKind   kind;
    regIdx   rs1;
    regIdx   rs2;
    regIdx   rd;
    dataWord imm;
  } microOp;

  // Contents of one pipeline stage register
  typedef struct packed {
    logic    valid;
    opKind   kind;
    regIdx   rs1;
    regIdx   rs2;
    regIdx   rd;
    dataWord imm;
    // Set for add and load that target a nonzero register
    logic    regWrite;
    logic    memRead;
    dataWord val1;
    dataWord val2;
    dataWord result;
  } stageDesc;

endpackage

// ==== design/pipeRegs.sv ====
// Decode, execute, memory and writeback stage registers with stall hold and bubble insertion
module pipeRegs (
  input  logic                clk,
  input  logic                rst,
  input  hazardPkg::microOp   inOp,
  input  logic                inValid,
  input  logic                stallF,
  input  logic                stallD,
  input  logic                flushD,
  input  logic                flushE,
  input  logic                flushM,
  input  logic                flushW,
  input  hazardPkg::dataWord  readA,
  input  hazardPkg::dataWord  readB,
  input  hazardPkg::dataWord  exeA,
  input  hazardPkg::dataWord  exeB,
  input  hazardPkg::dataWord  exeResult,
  input  hazardPkg::dataWord  memResult,
  output hazardPkg::stageDesc decStage,
  output hazardPkg::stageDesc exeStage,
  output hazardPkg::stageDesc memStage,
  output hazardPkg::stageDesc wbStage
);
  import hazardPkg::*;

  logic     consumed;
  stageDesc decNext;
  stageDesc exeNext;
  stageDesc memNext;
  stageDesc wbNext;

  // The fetch port hands over an op only when it is valid and accepted
  assign consumed = inValid & ~stallF;

  ////////////////////
  // Next stage contents
  ////////////////////

  always_comb begin
    decNext          = '0;
    decNext.valid    = consumed & ~flushD;
    decNext.kind     = inOp.kind;
    decNext.rs1      = inOp.rs1;
    decNext.rs2      = inOp.rs2;
    decNext.rd       = inOp.rd;
    decNext.imm      = inOp.imm;
    // Control bits are decoded once here and ride along with the op
    decNext.regWrite = (inOp.kind == opAdd || inOp.kind == opLoad) && (inOp.rd != '0);
    decNext.memRead  = (inOp.kind == opLoad);
  end

  always_comb begin
    exeNext       = decStage;
    exeNext.valid = decStage.valid & ~flushE;
    // Register file values read during decode
    exeNext.val1  = readA;
    exeNext.val2  = readB;
  end

  always_comb begin
    memNext        = exeStage;
    memNext.valid  = exeStage.valid & ~flushM;
    // Forwarded operands, so a store carries its final data word
    memNext.val1   = exeA;
    memNext.val2   = exeB;
    memNext.result = exeResult;
  end

  always_comb begin
    wbNext        = memStage;
    wbNext.valid  = memStage.valid & ~flushW;
    wbNext.result = memResult;
  end

  ////////////////////
  // Stage registers
  ////////////////////

  // Stall takes priority, so a held op survives an idle fetch cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      decStage.valid <= 1'b0;
    end else if (!stallD) begin
      decStage <= decNext;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exeStage.valid <= 1'b0;
    end else begin
      exeStage <= exeNext;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      memStage.valid <= 1'b0;
    end else begin
      memStage <= memNext;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wbStage.valid <= 1'b0;
    end else begin
      wbStage <= wbNext;
    end
  end

  // A stalled decode op must reappear unchanged on the next cycle
  assert property (@(posedge clk) disable iff (rst) stallD |=> $stable(decStage))
    else $error("pipeRegs: decode stage changed during a stall");

endmodule

// ==== design/pipeTop.sv ====
// Top level of the pipeline core joining control and datapath to the fetch and writeback ports
module pipeTop (
  input  logic               clk,
  input  logic               rst,
  input  logic               inValid,
  input  hazardPkg::microOp  inOp,
  output logic               inAccept,
  output logic               wbValid,
  output hazardPkg::regIdx   wbRd,
  output hazardPkg::dataWord wbData
);
  import hazardPkg::*;

  stageDesc decStage;
  stageDesc exeStage;
  stageDesc memStage;
  stageDesc wbStage;
  fwdSel    fwdA;
  fwdSel    fwdB;
  logic     stallF;
  logic     stallD;
  logic     flushD;
  logic     flushE;
  logic     flushM;
  logic     flushW;
  logic     branchTaken;
  dataWord  readA;
  dataWord  readB;
  dataWord  exeA;
  dataWord  exeB;
  dataWord  exeResult;
  dataWord  memResult;

  ////////////////////
  // Ports
  ////////////////////

  assign inAccept = ~stallF;
  // One strobe per retiring op that writes a register
  assign wbValid  = wbStage.valid & wbStage.regWrite;
  assign wbRd     = wbStage.rd;
  assign wbData   = wbStage.result;

  ////////////////////
  // Blocks
  ////////////////////

  hazard uHazard (
    .exeStage, .memStage, .wbStage, .decStage, .branchTaken, .inValid,
    .fwdA, .fwdB, .stallF, .stallD, .flushD, .flushE, .flushM, .flushW
  );

  pipeRegs uPipeRegs (
    .clk, .rst, .inOp, .inValid, .stallF, .stallD, .flushD, .flushE, .flushM, .flushW,
    .readA, .readB, .exeA, .exeB, .exeResult, .memResult,
    .decStage, .exeStage, .memStage, .wbStage
  );

  // Decode reads while writeback writes through the same file
  regFile uRegFile (
    .clk, .rst, .rs1(decStage.rs1), .rs2(decStage.rs2), .readA, .readB,
    .we(wbValid), .wrIdx(wbStage.rd), .wrData(wbStage.result)
  );

  execUnit uExecUnit (
    .exeStage, .fwdA, .fwdB, .memFwd(memResult), .wbFwd(wbStage.result),
    .exeA, .exeB, .exeResult, .branchTaken
  );

  dataRam uDataRam (
    .clk, .rst, .memStage, .memResult
  );

endmodule

// ==== design/regFile.sv ====
// Integer register file with two read ports, one write port and same-cycle write bypass
module regFile (
  input  logic               clk,
  input  logic               rst,
  input  hazardPkg::regIdx   rs1,
  input  hazardPkg::regIdx   rs2,
  output hazardPkg::dataWord readA,
  output hazardPkg::dataWord readB,
  input  logic               we,
  input  hazardPkg::regIdx   wrIdx,
  input  hazardPkg::dataWord wrData
);
  import hazardPkg::*;

  dataWord regs [numRegs];
  logic    hitA;
  logic    hitB;

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wrIdx != '0) begin
      // Register zero is never written
      regs[wrIdx] <= wrData;
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  // Writeback and decode share a cycle, so decode sees the value being written
  assign hitA = we && (wrIdx == rs1);
  assign hitB = we && (wrIdx == rs2);

  assign readA = (rs1 == '0) ? '0 : (hitA ? wrData : regs[rs1]);
  assign readB = (rs2 == '0) ? '0 : (hitB ? wrData : regs[rs2]);

endmodule

// ==== flist.f ====
design/hazardPkg.sv
design/hazard.sv
design/pipeRegs.sv
design/regFile.sv
design/execUnit.sv
design/dataRam.sv
design/pipeTop.sv
verif/pipeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator, run it into sim.log and judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module pipeTb -f flist.f -o pipeSim \
  && ./obj_dir/pipeSim 2>&1 | tee sim.log \
  && ! grep -q "STATUS: FAIL" sim.log \
  && echo "Result: simulation passed" \
  || { echo "Result: simulation failed"; exit 1; }

// ==== verif/pipeTb.sv ====
// Testbench for the pipeline core that runs directed and random micro-op programs against a model
module pipeTb;
  timeunit 1ns;
  timeprecision 1ps;

  import hazardPkg::*;

  // One register write as it shows up on the writeback port
  typedef struct packed {
    regIdx   rd;
    dataWord data;
  } wbWrite;

  logic    clk = 1'b0;
  logic    rst;
  logic    inValid;
  microOp  inOp;
  logic    inAccept;
  logic    wbValid;
  regIdx   wbRd;
  dataWord wbData;

  microOp  prog[$];
  int      gapBefore[$];
  wbWrite  expQ[$];
  wbWrite  expWrite;
  int      errors = 0;
  int      writesSeen = 0;
  logic    progReady = 1'b0;

  always #2 clk = ~clk;

  pipeTop u_dut (
    .clk, .rst, .inValid, .inOp, .inAccept, .wbValid, .wbRd, .wbData
  );

  ////////////////////
  // Program building
  ////////////////////

  // Appends one op with the number of idle fetch cycles placed ahead of it
  function automatic void pushOp(opKind k, int s1, int s2, int d, int imm, int gap);
    microOp op;
    op.kind = k;
    op.rs1  = regIdx'(s1);
    op.rs2  = regIdx'(s2);
    op.rd   = regIdx'(d);
    op.imm  = dataWord'(imm);
    prog.push_back(op);
    gapBefore.push_back(gap);
  endfunction

  // True when one of the last three ops redirects, so fetch must stay busy
  function automatic bit controlNear();
    bit found;
    found = 1'b0;
    for (int j = 1; j <= 3; j++) begin
      if (prog.size() >= j && prog[prog.size() - j].kind inside {opBranch, opRet, opTrap}) begin
        found = 1'b1;
      end
    end
    return found;
  endfunction

  function automatic void buildDirected();
    // Chained adds lean on memory and writeback forwarding, and x0 must read back as zero
    pushOp(opAdd, 0, 0, 1, 5, 0);
    pushOp(opAdd, 1, 1, 2, 1, 0);
    pushOp(opAdd, 2, 1, 3, 2, 0);
    pushOp(opAdd, 3, 3, 0, 7, 0);
    pushOp(opAdd, 0, 3, 4, 0, 0);
    pushOp(opAdd, 4, 0, 5, 1, 2);
    // Stores, then loads with a dependent op right behind each one
    pushOp(opStore, 0, 3, 0, 4, 0);
    pushOp(opStore, 1, 2, 0, 4, 0);
    pushOp(opLoad, 0, 0, 6, 4, 0);
    pushOp(opAdd, 6, 6, 7, 0, 0);
    pushOp(opLoad, 1, 0, 8, 4, 0);
    pushOp(opAdd, 1, 8, 9, 3, 0);
    pushOp(opStore, 9, 7, 0, 0, 0);
    pushOp(opLoad, 0, 0, 10, 3, 0);
    // Taken branch drops r11 and r12, the untaken one drops nothing
    pushOp(opBranch, 1, 1, 0, 0, 0);
    pushOp(opAdd, 0, 0, 11, 1, 0);
    pushOp(opAdd, 0, 0, 12, 2, 0);
    pushOp(opAdd, 0, 0, 13, 3, 0);
    pushOp(opBranch, 1, 2, 0, 0, 0);
    pushOp(opAdd, 0, 0, 14, 4, 0);
    pushOp(opAdd, 14, 0, 15, 5, 0);
    // Ret and trap each drop the next three ops
    pushOp(opRet, 0, 0, 22, 0, 0);
    for (int j = 0; j < 3; j++) begin
      pushOp(opAdd, 0, 0, 16 + j, 9, 0);
    end
    pushOp(opAdd, 0, 0, 19, 6, 0);
    pushOp(opTrap, 0, 0, 20, 0, 0);
    for (int j = 0; j < 3; j++) begin
      pushOp(opAdd, 0, 0, 16 + j, 11, 0);
    end
    pushOp(opAdd, 19, 0, 21, 1, 0);
  endfunction

  // Random mix over a few registers so that hazards come up often
  function automatic void buildRandom(int count);
    int    pick;
    int    gap;
    int    s1;
    int    s2;
    opKind k;
    for (int n = 0; n < count; n++) begin
      pick = int'($urandom_range(99, 0));
      if (pick < 40) k = opAdd;
      else if (pick < 60) k = opLoad;
      else if (pick < 75) k = opStore;
      else if (pick < 87) k = opBranch;
      else if (pick < 94) k = opRet;
      else k = opTrap;
      s1 = int'($urandom_range(7, 0));
      s2 = int'($urandom_range(7, 0));
      if (k == opBranch && $urandom_range(2, 0) == 0) s2 = s1;
      gap = 0;
      if (!controlNear() && $urandom_range(9, 0) == 0) gap = int'($urandom_range(3, 1));
      pushOp(k, s1, s2, int'($urandom_range(7, 0)), int'($urandom_range(15, 0)), gap);
    end
  endfunction

  ////////////////////
  // Reference model
  ////////////////////

  // Retires the program in order, applies the squash counts and queues every register write
  function automatic void computeExpected();
    dataWord regs [numRegs];
    dataWord ram [ramWords];
    dataWord a;
    dataWord b;
    int      idx;
    int      skip;
    wbWrite  w;
    for (int i = 0; i < numRegs; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < ramWords; i++) begin
      ram[i] = '0;
    end
    skip = 0;
    foreach (prog[i]) begin
      if (skip > 0) begin
        // Fetched in the shadow of a control op
        skip--;
      end else begin
        a      = regs[prog[i].rs1];
        b      = regs[prog[i].rs2];
        idx    = int'((a + prog[i].imm) % ramWords);
        w.rd   = prog[i].rd;
        w.data = '0;
        case (prog[i].kind)
          opAdd:    w.data = a + b + prog[i].imm;
          opLoad:   w.data = ram[idx];
          opStore:  ram[idx] = b;
          opBranch: skip = (a == b) ? 2 : 0;
          default:  skip = 3;
        endcase
        // Only adds and loads write, and x0 never changes
        if ((prog[i].kind == opAdd || prog[i].kind == opLoad) && prog[i].rd != '0) begin
          regs[prog[i].rd] = w.data;
          expQ.push_back(w);
        end
      end
    end
  endfunction

  ////////////////////
  // Checking
  ////////////////////

  task automatic checkValue(string name, dataWord got, dataWord want);
    if (got !== want) begin
      $display("FAIL time %0t %s got 0x%08h expected 0x%08h", $time, name, got, want);
      errors++;
    end
  endtask

  // Writeback comes straight from stage registers, so mid-cycle values are settled
  always @(negedge clk) begin
    if (!rst && wbValid) begin
      if (expQ.size() == 0) begin
        $display("Unexpected writeback to register %0d at time %0t", wbRd, $time);
        errors++;
      end else begin
        expWrite = expQ.pop_front();
        checkValue("wbRd", dataWord'(wbRd), dataWord'(expWrite.rd));
        checkValue("wbData", wbData, expWrite.data);
        writesSeen++;
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  // Presents one op and holds it until a clock edge takes it
  task automatic driveOp(microOp op);
    logic taken;
    inValid = 1'b1;
    inOp    = op;
    taken   = 1'b0;
    while (!taken) begin
      // inAccept has settled by mid-cycle
      #1;
      taken = inAccept;
      @(negedge clk);
    end
  endtask

  initial begin
    rst     = 1'b1;
    inValid = 1'b0;
    inOp    = '0;
    void'($urandom(32'h4d32));
    buildDirected();
    buildRandom(300);
    // Trailing adds to x0 give the last control op real fetches to squash
    for (int j = 0; j < 3; j++) begin
      pushOp(opAdd, 0, 0, 0, 0, 0);
    end
    computeExpected();
    progReady = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    foreach (prog[i]) begin
      if (gapBefore[i] > 0) begin
        inValid = 1'b0;
        repeat (gapBefore[i]) @(negedge clk);
      end
      driveOp(prog[i]);
    end
    inValid = 1'b0;
    while (expQ.size() != 0) begin
      @(negedge clk);
    end
    // A few more cycles so that a stray extra write is still caught
    repeat (10) @(negedge clk);
    $display("Checked %0d writes, %0d errors", writesSeen, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Each op gets a generous share of cycles on top of a fixed drain allowance
  initial begin
    wait (progReady);
    repeat (20 * prog.size() + 100) @(posedge clk);
    $display("Timeout: %0d writes still pending after %0d ops", expQ.size(), prog.size());
    $display("STATUS: FAIL");
    $finish;
  end

endmodule
